// File: compile.f
+incdir+include
hw/mips_pkg.sv
hw/mips_control.sv
hw/mips_alu_control.sv
hw/mips_alu.sv
hw/mips_regfile.sv
hw/mips_next_pc.sv
hw/mips_cpu_harvard.sv
dv/mips_mem_model.sv
dv/mips_tb.sv

// File: Bender.yml
package:
  name: mips_cpu_harvard

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/mips_pkg.sv
      - hw/mips_control.sv
      - hw/mips_alu_control.sv
      - hw/mips_alu.sv
      - hw/mips_regfile.sv
      - hw/mips_next_pc.sv
      - hw/mips_cpu_harvard.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - dv/mips_mem_model.sv
      - dv/mips_tb.sv

// File: dv/mips_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_macros.svh"

module mips_tb;
    import mips_pkg::*;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 16;
    localparam int STALL_CYCLES = 6;
    localparam int PROG_WORDS   = 64;
    localparam int PROG_AW      = $clog2(PROG_WORDS);
    localparam int NUM_TESTS    = 6;

    logic        clk;
    logic        reset;
    logic        clk_enable;
    logic        active;
    logic [31:0] register_v0;
    logic [31:0] instr_address;
    logic [31:0] instr_readdata;
    logic [31:0] data_address;
    logic        data_write;
    logic        data_read;
    logic [31:0] data_writedata;
    logic [31:0] data_readdata;

    logic [31:0] prog [PROG_WORDS];
    int          prog_len;
    integer      seed;
    logic [31:0] mem_start_pc;
    logic [31:0] ctrl_start_pc;
    logic [31:0] stall_pc;

    // Reference model state
    logic [31:0] m_regs [32];
    logic [31:0] m_pc;
    logic        m_active;
    logic [31:0] m_mem [logic [31:0]];
    logic [31:0] cur_ins;
    logic        exp_store;
    logic        exp_load;
    logic [31:0] exp_addr;
    logic [31:0] exp_wdata;

    int errors;
    int failed_tests;
    int test_start;

    mips_cpu_harvard dut (
        .clk            (clk),
        .reset          (reset),
        .active         (active),
        .register_v0    (register_v0),
        .clk_enable     (clk_enable),
        .instr_address  (instr_address),
        .instr_readdata (instr_readdata),
        .data_address   (data_address),
        .data_write     (data_write),
        .data_read      (data_read),
        .data_writedata (data_writedata),
        .data_readdata  (data_readdata)
    );

    mips_mem_model #(.ROM_WORDS(PROG_WORDS)) mem (
        .clk            (clk),
        .instr_address  (instr_address),
        .instr_readdata (instr_readdata),
        .data_address   (data_address),
        .data_write     (data_write),
        .data_read      (data_read),
        .data_writedata (data_writedata),
        .data_readdata  (data_readdata)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] rtype_word(funct_e fn, logic [4:0] rs, logic [4:0] rt,
                                               logic [4:0] rd);
        return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] itype_word(opcode_e op, logic [4:0] rs, logic [4:0] rt,
                                               logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] jump_word(opcode_e op, logic [31:0] target);
        return {op, target[27:2]};
    endfunction

    function automatic logic [31:0] word_address(int idx);
        return `MIPS_RESET_VECTOR + 32'(idx) * 32'd4;
    endfunction

    function automatic logic [31:0] program_word(logic [31:0] pc);
        logic [31:0] offset;
        offset = pc - `MIPS_RESET_VECTOR;
        if (offset < PROG_WORDS * 4) begin
            return prog[offset[2 +: PROG_AW]];
        end
        return '0;
    endfunction

    function automatic logic [15:0] random_imm();
        return 16'($random(seed));
    endfunction

    task automatic emit(logic [31:0] word);
        prog[prog_len] = word;
        prog_len++;
    endtask

    task automatic build_program();
        funct_e      alu_fns [7];
        logic [15:0] offset;
        int          k;
        alu_fns = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_SLT, FN_SLTU};
        for (int i = 0; i < PROG_WORDS; i++) begin
            prog[i] = '0;
        end
        prog_len = 0;
        emit(itype_word(OP_ADDIU, 5'd0, 5'd8, random_imm()));
        emit(itype_word(OP_ADDIU, 5'd0, 5'd9, random_imm()));
        emit(itype_word(OP_ADDIU, 5'd8, 5'd2, random_imm()));
        emit(itype_word(OP_ORI, 5'd2, 5'd2, random_imm()));
        emit(itype_word(OP_ANDI, 5'd2, 5'd2, random_imm()));
        emit(itype_word(OP_XORI, 5'd2, 5'd2, random_imm()));
        emit(itype_word(OP_SLTI, 5'd8, 5'd2, random_imm()));
        foreach (alu_fns[i]) begin
            emit(rtype_word(alu_fns[i], 5'd8, 5'd9, 5'd2));
        end

        // Store then load back, offset within 128 bytes of the base
        mem_start_pc = word_address(prog_len);
        offset = random_imm() & 16'h00FC;
        offset = offset - 16'h0080;
        emit(itype_word(OP_ADDIU, 5'd0, 5'd10, 16'h0200));
        emit(itype_word(OP_SW, 5'd10, 5'd8, offset));
        emit(itype_word(OP_LW, 5'd10, 5'd2, offset));

        ctrl_start_pc = word_address(prog_len);
        emit(itype_word(OP_BEQ, 5'd8, 5'd8, 16'd1));
        emit(itype_word(OP_ADDIU, 5'd0, 5'd2, 16'h07ff));
        emit(itype_word(OP_BNE, 5'd8, 5'd8, 16'd3));
        emit(jump_word(OP_J, word_address(prog_len + 2)));
        emit(itype_word(OP_ADDIU, 5'd0, 5'd2, 16'h07ee));
        k = prog_len;
        emit(jump_word(OP_JAL, word_address(k + 4)));
        stall_pc = word_address(k + 1);
        emit(itype_word(OP_SW, 5'd10, 5'd9, 16'h0004));
        emit(itype_word(OP_ADDIU, 5'd2, 5'd2, 16'h0001));
        emit(rtype_word(FN_JR, 5'd0, 5'd0, 5'd0));
        // Subroutine copies the link register to v0
        emit(rtype_word(FN_ADDU, 5'd31, 5'd0, 5'd2));
        emit(rtype_word(FN_JR, 5'd31, 5'd0, 5'd0));

        for (int i = 0; i < PROG_WORDS; i++) begin
            mem.rom[i] = prog[i];
        end
    endtask

    task automatic set_reg(logic [4:0] idx, logic [31:0] value);
        if (idx != 5'd0) begin
            m_regs[idx] = value;
        end
    endtask

    task automatic reset_model();
        for (int i = 0; i < 32; i++) begin
            m_regs[i] = '0;
        end
        m_pc     = `MIPS_RESET_VECTOR;
        m_active = 1'b1;
        m_mem.delete();
    endtask

    task automatic retire_instruction();
        logic [31:0] ins;
        logic [31:0] rs_val;
        logic [31:0] rt_val;
        logic [31:0] sext;
        logic [31:0] zext;
        logic [31:0] seq_pc;
        logic [31:0] next_pc;
        logic [31:0] addr;
        ins     = program_word(m_pc);
        rs_val  = m_regs[ins[25:21]];
        rt_val  = m_regs[ins[20:16]];
        sext    = {{16{ins[15]}}, ins[15:0]};
        zext    = {16'h0000, ins[15:0]};
        seq_pc  = m_pc + 32'd4;
        next_pc = seq_pc;
        addr    = rs_val + sext;
        case (opcode_e'(ins[31:26]))
            OP_RTYPE: begin
                case (funct_e'(ins[5:0]))
                    FN_ADDU: set_reg(ins[15:11], rs_val + rt_val);
                    FN_SUBU: set_reg(ins[15:11], rs_val - rt_val);
                    FN_AND:  set_reg(ins[15:11], rs_val & rt_val);
                    FN_OR:   set_reg(ins[15:11], rs_val | rt_val);
                    FN_XOR:  set_reg(ins[15:11], rs_val ^ rt_val);
                    FN_SLT:  set_reg(ins[15:11], ($signed(rs_val) < $signed(rt_val)) ? 1 : 0);
                    FN_SLTU: set_reg(ins[15:11], (rs_val < rt_val) ? 32'd1 : 32'd0);
                    FN_JR: begin
                        next_pc = rs_val;
                        if (rs_val == '0) begin
                            m_active = 1'b0;
                        end
                    end
                    default: ;
                endcase
            end
            OP_J:     next_pc = {seq_pc[31:28], ins[25:0], 2'b00};
            OP_JAL: begin
                next_pc = {seq_pc[31:28], ins[25:0], 2'b00};
                set_reg(5'd31, seq_pc);
            end
            OP_BEQ:   if (rs_val == rt_val) next_pc = seq_pc + (sext << 2);
            OP_BNE:   if (rs_val != rt_val) next_pc = seq_pc + (sext << 2);
            OP_ADDIU: set_reg(ins[20:16], rs_val + sext);
            OP_SLTI:  set_reg(ins[20:16], ($signed(rs_val) < $signed(sext)) ? 32'd1 : 32'd0);
            OP_ANDI:  set_reg(ins[20:16], rs_val & zext);
            OP_ORI:   set_reg(ins[20:16], rs_val | zext);
            OP_XORI:  set_reg(ins[20:16], rs_val ^ zext);
            // Unwritten RAM words hold the inverted address
            OP_LW:    set_reg(ins[20:16], m_mem.exists(addr) ? m_mem[addr] : ~addr);
            OP_SW:    m_mem[addr] = rt_val;
            default: ;
        endcase
        m_pc = next_pc;
    endtask

    always @(posedge clk) begin
        if (reset) begin
            reset_model();
        end else if (clk_enable && m_active) begin
            retire_instruction();
        end
    end

    // Strobes expected from the instruction the model is about to retire
    assign cur_ins = program_word(m_pc);

    always_comb begin
        exp_store = m_active && (cur_ins[31:26] == OP_SW);
        exp_load  = m_active && (cur_ins[31:26] == OP_LW);
        exp_addr  = m_regs[cur_ins[25:21]] + {{16{cur_ins[15]}}, cur_ins[15:0]};
        exp_wdata = m_regs[cur_ins[20:16]];
    end

    reset_state: assert property (@(posedge clk)
        reset |=> (instr_address == `MIPS_RESET_VECTOR && active && register_v0 == '0
                   && !data_write))
    else begin
        $display("ERROR reset state: instr_address %h active %h register_v0 %h data_write %h",
                 $sampled(instr_address), $sampled(active), $sampled(register_v0),
                 $sampled(data_write));
        errors++;
    end

    pc_follows: assert property (@(posedge clk) disable iff (reset) instr_address == m_pc)
    else begin
        $display("ERROR instr_address: got %h expected %h", $sampled(instr_address),
                 $sampled(m_pc));
        errors++;
    end

    v0_follows: assert property (@(posedge clk) disable iff (reset) register_v0 == m_regs[2])
    else begin
        $display("ERROR register_v0: got %h expected %h", $sampled(register_v0),
                 $sampled(m_regs[2]));
        errors++;
    end

    active_follows: assert property (@(posedge clk) disable iff (reset) active == m_active)
    else begin
        $display("ERROR active: got %h expected %h", $sampled(active), $sampled(m_active));
        errors++;
    end

    write_strobe: assert property (@(posedge clk) disable iff (reset)
        data_write == (exp_store && clk_enable))
    else begin
        $display("ERROR data_write: got %h expected %h", $sampled(data_write),
                 $sampled(exp_store && clk_enable));
        errors++;
    end

    read_strobe: assert property (@(posedge clk) disable iff (reset)
        data_read == exp_load)
    else begin
        $display("ERROR data_read: got %h expected %h", $sampled(data_read),
                 $sampled(exp_load));
        errors++;
    end

    store_fields: assert property (@(posedge clk) disable iff (reset)
        (exp_store && clk_enable) |-> (data_address == exp_addr && data_writedata == exp_wdata))
    else begin
        $display("ERROR data_address %h expected %h, data_writedata %h expected %h",
                 $sampled(data_address), $sampled(exp_addr), $sampled(data_writedata),
                 $sampled(exp_wdata));
        errors++;
    end

    stall_holds: assert property (@(posedge clk) disable iff (reset)
        !clk_enable |=> ($stable(instr_address) && $stable(register_v0)))
    else begin
        $display("instr_address or register_v0 changed while clk_enable was low");
        errors++;
    end

    halt_sticky: assert property (@(posedge clk) disable iff (reset)
        !active |=> (!active && !data_write))
    else begin
        $display("processor left the halted state or wrote data after halting");
        errors++;
    end

    task automatic report_test(string name, int start);
        if (errors > start) begin
            failed_tests++;
        end
        $display("test %-8s %s (%0d errors)", name, (errors > start) ? "FAIL" : "ok",
                 errors - start);
    endtask

    task automatic wait_for_pc(logic [31:0] target);
        while (instr_address !== target) begin
            @(posedge clk);
            #1;
        end
    endtask

    initial begin : watchdog
        #((RESET_CYCLES + PROG_WORDS + STALL_CYCLES + 20) * CLK_PERIOD);
        $display("watchdog expired before the processor halted");
        $display("tests failed");
        $finish;
    end

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        clk_enable   = 1'b1;
        errors       = 0;
        failed_tests = 0;
        seed         = 32'hefe924c8;
        build_program();

        test_start = errors;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 reset = 1'b0;
        @(posedge clk);
        #1;
        report_test("reset", test_start);

        test_start = errors;
        wait_for_pc(mem_start_pc);
        @(posedge clk);
        #1;
        report_test("alu", test_start);

        test_start = errors;
        wait_for_pc(ctrl_start_pc);
        @(posedge clk);
        #1;
        report_test("memory", test_start);

        // Freeze on the store after the subroutine returns
        test_start = errors;
        wait_for_pc(stall_pc);
        clk_enable = 1'b0;
        @(posedge clk);
        #1;
        report_test("control", test_start);

        test_start = errors;
        repeat (STALL_CYCLES - 1) @(posedge clk);
        #1 clk_enable = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        report_test("stall", test_start);

        test_start = errors;
        while (active === 1'b1) begin
            @(posedge clk);
            #1;
        end
        repeat (4) @(posedge clk);
        #1;
        report_test("halt", test_start);

        $display("summary: %0d tests, %0d failing, %0d errors", NUM_TESTS, failed_tests,
                 errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/mips_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_macros.svh"

module mips_mem_model #(
    parameter int ROM_WORDS = 64,
    parameter int RAM_WORDS = 1024
) (
    input  logic                  clk,
    input  logic [`MIPS_XLEN-1:0] instr_address,
    output logic [`MIPS_XLEN-1:0] instr_readdata,
    input  logic [`MIPS_XLEN-1:0] data_address,
    input  logic                  data_write,
    input  logic                  data_read,
    input  logic [`MIPS_XLEN-1:0] data_writedata,
    output logic [`MIPS_XLEN-1:0] data_readdata
);

    localparam int ROM_AW = $clog2(ROM_WORDS);
    localparam int RAM_AW = $clog2(RAM_WORDS);

    // Loaded by the testbench before reset
    logic [`MIPS_XLEN-1:0] rom [ROM_WORDS];
    logic [`MIPS_XLEN-1:0] ram [RAM_WORDS];
    logic [`MIPS_XLEN-1:0] rom_offset;

    assign rom_offset = instr_address - `MIPS_RESET_VECTOR;

    // Outside the ROM window fetches read as zero
    assign instr_readdata = (rom_offset < ROM_WORDS * 4) ? rom[rom_offset[2 +: ROM_AW]] : '0;

    // Data RAM aliases on the low address bits
    assign data_readdata = data_read ? ram[data_address[2 +: RAM_AW]] : '0;

    initial begin
        // Each word holds the inverse of its own byte address
        for (int i = 0; i < RAM_WORDS; i++) begin
            ram[i] = ~(32'(i) << 2);
        end
    end

    always @(posedge clk) begin
        if (data_write) begin
            ram[data_address[2 +: RAM_AW]] <= data_writedata;
        end
    end

endmodule

`default_nettype wire

// File: hw/mips_cpu_harvard.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_macros.svh"

module mips_cpu_harvard (
    input  logic                  clk,
    input  logic                  reset,
    output logic                  active,
    output logic [`MIPS_XLEN-1:0] register_v0,

    input  logic                  clk_enable,

    output logic [`MIPS_XLEN-1:0] instr_address,
    input  logic [`MIPS_XLEN-1:0] instr_readdata,

    output logic [`MIPS_XLEN-1:0] data_address,
    output logic                  data_write,
    output logic                  data_read,
    output logic [`MIPS_XLEN-1:0] data_writedata,
    input  logic [`MIPS_XLEN-1:0] data_readdata
);
    import mips_pkg::*;

    // Instruction fields
    opcode_e                    instr_opcode;
    logic [`MIPS_REG_IDX_W-1:0] rs;
    logic [`MIPS_REG_IDX_W-1:0] rt;
    logic [`MIPS_REG_IDX_W-1:0] rd;
    logic [5:0]                 funct;
    logic [15:0]                imm;
    logic [25:0]                jump_field;

    assign instr_opcode = opcode_e'(instr_readdata[31:26]);
    assign rs           = instr_readdata[25:21];
    assign rt           = instr_readdata[20:16];
    assign rd           = instr_readdata[15:11];
    assign funct        = instr_readdata[5:0];
    assign imm          = instr_readdata[15:0];
    assign jump_field   = instr_readdata[25:0];

    logic       reg_dst;
    logic       alu_src;
    logic       imm_zero_ext;
    logic       mem_read;
    logic       mem_write;
    logic       mem_to_reg;
    logic       reg_write;
    logic       branch_eq;
    logic       branch_ne;
    logic       jump;
    logic       link;
    alu_class_e alu_class;
    alu_op_e    alu_op;
    logic       jr_sel;

    mips_control u_control (
        .instr_opcode (instr_opcode),
        .reg_dst      (reg_dst),
        .alu_src      (alu_src),
        .imm_zero_ext (imm_zero_ext),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .mem_to_reg   (mem_to_reg),
        .reg_write    (reg_write),
        .branch_eq    (branch_eq),
        .branch_ne    (branch_ne),
        .jump         (jump),
        .link         (link),
        .alu_class    (alu_class)
    );

    mips_alu_control u_alu_control (
        .alu_class (alu_class),
        .funct     (funct),
        .alu_op    (alu_op),
        .jr_sel    (jr_sel)
    );

    logic [`MIPS_XLEN-1:0]      imm_sext;
    logic [`MIPS_XLEN-1:0]      imm_ext;
    logic [`MIPS_XLEN-1:0]      rs_data;
    logic [`MIPS_XLEN-1:0]      rt_data;
    logic [`MIPS_XLEN-1:0]      alu_b;
    logic [`MIPS_XLEN-1:0]      alu_result;
    logic                       alu_zero;
    logic [`MIPS_XLEN-1:0]      pc;
    logic [`MIPS_XLEN-1:0]      pc_plus4;
    logic [`MIPS_REG_IDX_W-1:0] wb_index;
    logic [`MIPS_XLEN-1:0]      wb_data;
    logic                       wb_enable;

    assign imm_sext = {{(`MIPS_XLEN-16){imm[15]}}, imm};
    // Logical immediates are zero-extended
    assign imm_ext  = imm_zero_ext ? {{(`MIPS_XLEN-16){1'b0}}, imm} : imm_sext;
    assign alu_b    = alu_src ? imm_ext : rt_data;

    mips_alu u_alu (
        .op     (alu_op),
        .a      (rs_data),
        .b      (alu_b),
        .result (alu_result),
        .zero   (alu_zero)
    );

    // JAL links into r31
    assign wb_index  = link ? `MIPS_REG_IDX_W'(31) : (reg_dst ? rd : rt);
    assign wb_data   = link ? pc_plus4 : (mem_to_reg ? data_readdata : alu_result);
    assign wb_enable = reg_write && !jr_sel && active;

    mips_regfile u_regfile (
        .clk          (clk),
        .reset        (reset),
        .clk_enable   (clk_enable),
        .write_enable (wb_enable),
        .read_index_a (rs),
        .read_index_b (rt),
        .write_index  (wb_index),
        .write_data   (wb_data),
        .read_data_a  (rs_data),
        .read_data_b  (rt_data),
        .register_v0  (register_v0)
    );

    mips_next_pc u_next_pc (
        .clk        (clk),
        .reset      (reset),
        .clk_enable (clk_enable),
        .branch_eq  (branch_eq),
        .branch_ne  (branch_ne),
        .zero       (alu_zero),
        .jump       (jump),
        .jr_sel     (jr_sel),
        .offset     (imm_sext),
        .rs_value   (rs_data),
        .jump_field (jump_field),
        .pc         (pc),
        .pc_plus4   (pc_plus4),
        .active     (active)
    );

    assign instr_address  = pc;
    assign data_address   = alu_result;
    assign data_writedata = rt_data;
    assign data_read      = mem_read && active;
    // Stores only land on an enabled edge while running
    assign data_write     = mem_write && clk_enable && active;

endmodule

`default_nettype wire

// File: hw/mips_next_pc.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_macros.svh"

module mips_next_pc (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  clk_enable,
    input  logic                  branch_eq,
    input  logic                  branch_ne,
    input  logic                  zero,
    input  logic                  jump,
    input  logic                  jr_sel,
    input  logic [`MIPS_XLEN-1:0] offset,
    input  logic [`MIPS_XLEN-1:0] rs_value,
    input  logic [25:0]           jump_field,
    output logic [`MIPS_XLEN-1:0] pc,
    output logic [`MIPS_XLEN-1:0] pc_plus4,
    output logic                  active
);

    logic [`MIPS_XLEN-1:0] next_pc;
    logic                  branch_taken;

    assign pc_plus4     = pc + `MIPS_XLEN'(4);
    assign branch_taken = (branch_eq && zero) || (branch_ne && !zero);

    always_comb begin
        if (jr_sel) begin
            next_pc = rs_value;
        end else if (jump) begin
            // Region stays that of the delay-slot address
            next_pc = {pc_plus4[`MIPS_XLEN-1:`MIPS_XLEN-4], jump_field, 2'b00};
        end else if (branch_taken) begin
            next_pc = pc_plus4 + {offset[`MIPS_XLEN-3:0], 2'b00};
        end else begin
            next_pc = pc_plus4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc     <= `MIPS_RESET_VECTOR;
            active <= 1'b1;
        end else if (clk_enable && active) begin
            pc <= next_pc;
            // JR to address zero halts
            if (jr_sel && rs_value == '0) begin
                active <= 1'b0;
            end
        end
    end

    // Halt parks the PC at zero
    assert property (@(posedge clk) disable iff (reset)
        !active |-> (pc == '0));

endmodule

`default_nettype wire

// File: hw/mips_regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_macros.svh"

module mips_regfile (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       clk_enable,
    input  logic                       write_enable,
    input  logic [`MIPS_REG_IDX_W-1:0] read_index_a,
    input  logic [`MIPS_REG_IDX_W-1:0] read_index_b,
    input  logic [`MIPS_REG_IDX_W-1:0] write_index,
    input  logic [`MIPS_XLEN-1:0]      write_data,
    output logic [`MIPS_XLEN-1:0]      read_data_a,
    output logic [`MIPS_XLEN-1:0]      read_data_b,
    output logic [`MIPS_XLEN-1:0]      register_v0
);

    logic [`MIPS_XLEN-1:0] regs [`MIPS_NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (clk_enable && write_enable && write_index != '0) begin
            regs[write_index] <= write_data;
        end
    end

    assign read_data_a = regs[read_index_a];
    assign read_data_b = regs[read_index_b];

    // v0 is r2
    assign register_v0 = regs[2];

    // r0 stays zero since its writes are dropped above
    assert property (@(posedge clk) disable iff (reset)
        (read_index_a == '0) |-> (read_data_a == '0));

endmodule

`default_nettype wire

// File: hw/mips_alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_macros.svh"

module mips_alu (
    input  mips_pkg::alu_op_e      op,
    input  logic [`MIPS_XLEN-1:0]  a,
    input  logic [`MIPS_XLEN-1:0]  b,
    output logic [`MIPS_XLEN-1:0]  result,
    output logic                   zero
);
    import mips_pkg::*;

    logic slt_signed;
    logic slt_unsigned;

    assign slt_signed   = $signed(a) < $signed(b);
    assign slt_unsigned = a < b;

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            // Compare results are a single 0/1 in the low bit
            ALU_SLT:  result = {{(`MIPS_XLEN-1){1'b0}}, slt_signed};
            ALU_SLTU: result = {{(`MIPS_XLEN-1){1'b0}}, slt_unsigned};
            default:  result = '0;
        endcase
    end

    // Branch compare uses the SUB result
    assign zero = (result == '0);

endmodule

`default_nettype wire

// File: hw/mips_alu_control.sv
`timescale 1ns/1ps
`default_nettype none

module mips_alu_control (
    input  mips_pkg::alu_class_e alu_class,
    input  logic [5:0]           funct,
    output mips_pkg::alu_op_e    alu_op,
    output logic                 jr_sel
);
    import mips_pkg::*;

    always_comb begin
        jr_sel = 1'b0;
        case (alu_class)
            CLASS_ADD:  alu_op = ALU_ADD;
            CLASS_SUB:  alu_op = ALU_SUB;
            CLASS_SLTI: alu_op = ALU_SLT;
            CLASS_ANDI: alu_op = ALU_AND;
            CLASS_ORI:  alu_op = ALU_OR;
            CLASS_XORI: alu_op = ALU_XOR;
            CLASS_RTYPE: begin
                case (funct_e'(funct))
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_XOR:  alu_op = ALU_XOR;
                    FN_SLT:  alu_op = ALU_SLT;
                    FN_SLTU: alu_op = ALU_SLTU;
                    FN_JR: begin
                        alu_op = ALU_ADD;
                        jr_sel = 1'b1;
                    end
                    default: alu_op = ALU_ADD;
                endcase
            end
            default: alu_op = ALU_ADD;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/mips_control.sv
`timescale 1ns/1ps
`default_nettype none

module mips_control (
    input  mips_pkg::opcode_e    instr_opcode,
    output logic                 reg_dst,
    output logic                 alu_src,
    output logic                 imm_zero_ext,
    output logic                 mem_read,
    output logic                 mem_write,
    output logic                 mem_to_reg,
    output logic                 reg_write,
    output logic                 branch_eq,
    output logic                 branch_ne,
    output logic                 jump,
    output logic                 link,
    output mips_pkg::alu_class_e alu_class
);
    import mips_pkg::*;

    always_comb begin
        // No-op defaults, nothing written
        reg_dst      = 1'b0;
        alu_src      = 1'b0;
        imm_zero_ext = 1'b0;
        mem_read     = 1'b0;
        mem_write    = 1'b0;
        mem_to_reg   = 1'b0;
        reg_write    = 1'b0;
        branch_eq    = 1'b0;
        branch_ne    = 1'b0;
        jump         = 1'b0;
        link         = 1'b0;
        alu_class    = CLASS_ADD;

        case (instr_opcode)
            OP_RTYPE: begin
                reg_dst   = 1'b1;
                reg_write = 1'b1;
                alu_class = CLASS_RTYPE;
            end
            OP_J: begin
                jump = 1'b1;
            end
            OP_JAL: begin
                jump      = 1'b1;
                link      = 1'b1;
                reg_write = 1'b1;
            end
            OP_BEQ: begin
                branch_eq = 1'b1;
                alu_class = CLASS_SUB;
            end
            OP_BNE: begin
                branch_ne = 1'b1;
                alu_class = CLASS_SUB;
            end
            OP_ADDIU: begin
                alu_src   = 1'b1;
                reg_write = 1'b1;
            end
            OP_SLTI: begin
                alu_src   = 1'b1;
                reg_write = 1'b1;
                alu_class = CLASS_SLTI;
            end
            OP_ANDI, OP_ORI, OP_XORI: begin
                alu_src      = 1'b1;
                imm_zero_ext = 1'b1;
                reg_write    = 1'b1;
                alu_class    = (instr_opcode == OP_ANDI) ? CLASS_ANDI :
                               (instr_opcode == OP_ORI)  ? CLASS_ORI  : CLASS_XORI;
            end
            OP_LW: begin
                alu_src    = 1'b1;
                mem_read   = 1'b1;
                mem_to_reg = 1'b1;
                reg_write  = 1'b1;
            end
            OP_SW: begin
                alu_src   = 1'b1;
                mem_write = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/mips_pkg.sv
`default_nettype none

package mips_pkg;

    // Primary opcodes, instr[31:26]
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_JAL   = 6'h03,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDIU = 6'h09,
        OP_SLTI  = 6'h0A,
        OP_ANDI  = 6'h0C,
        OP_ORI   = 6'h0D,
        OP_XORI  = 6'h0E,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2B
    } opcode_e;

    // R-type function codes, instr[5:0]
    typedef enum logic [5:0] {
        FN_JR   = 6'h08,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2A,
        FN_SLTU = 6'h2B
    } funct_e;

    // What the main decoder asks of the ALU decoder
    typedef enum logic [2:0] {
        CLASS_ADD,
        CLASS_SUB,
        CLASS_RTYPE,
        CLASS_SLTI,
        CLASS_ANDI,
        CLASS_ORI,
        CLASS_XORI
    } alu_class_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU
    } alu_op_e;

endpackage

`default_nettype wire

// File: include/mips_macros.svh
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// Datapath and address width
`define MIPS_XLEN 32

// Register file geometry
`define MIPS_REG_IDX_W 5
`define MIPS_NUM_REGS 32

// First fetch address after reset
`define MIPS_RESET_VECTOR 32'hBFC00000

`endif
